// ==== arb_defs.svh ====
// shared sizing macros for the message concentrator
// channel count, message width, queue depth, counter and address widths

`ifndef ARB_DEFS_SVH
`define ARB_DEFS_SVH

// number of input channels, sizes request and grant vectors
`define ARB_N 4

// width of one message word
`define ARB_DW 16

// entries in each channel queue
`define ARB_QDEPTH 4

// grant counter width, counters wrap at the top
`define ARB_CNTW 16

// register address width of the config port
`define ARB_ADDRW 3

`endif

// ==== arb_pkg.sv ====
// package for the message concentrator
// register address map and derived channel index width

`default_nettype none

`include "arb_defs.svh"

package arb_pkg;

  // bits needed to name one channel
  localparam int IdxW = (`ARB_N > 1) ? $clog2(`ARB_N) : 1;

  // config register addresses, anything not listed reads as zero
  typedef enum logic [`ARB_ADDRW-1:0] {
    ARB_REG_ENABLE = 3'd0,
    ARB_REG_CNT0   = 3'd1,
    ARB_REG_CNT1   = 3'd2,
    ARB_REG_CNT2   = 3'd3,
    ARB_REG_CNT3   = 3'd4
  } arb_reg_e;

endpackage

`default_nettype wire

// ==== rr_arbiter_tree.sv ====
// round-robin N to 1 arbiter built as a binary tree
// data is muxed at every node alongside the request
// registered prefix mask gives the rotating priority

`timescale 1ns/100ps
`default_nettype none

`include "arb_defs.svh"

module rr_arbiter_tree #(
  parameter int N  = `ARB_N,
  parameter int DW = `ARB_DW
) (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire  [N-1:0]              req_i,
  input  wire  [DW-1:0]             data_i [N],
  output logic [N-1:0]              gnt_o,
  output logic [arb_pkg::IdxW-1:0]  idx_o,
  output logic                      valid_o,
  output logic [DW-1:0]             data_o,
  input  wire                       ready_i
);

  if (N == 1) begin : gen_bypass

    // a single requester needs no arbitration at all
    assign valid_o  = req_i[0];
    assign data_o   = data_i[0];
    assign gnt_o[0] = req_i[0] & ready_i;
    assign idx_o    = '0;

  end else begin : gen_tree_arb

    // tree depth, leaves sit on the last level
    localparam int Lvls  = $clog2(N);
    // a full binary tree over 2**Lvls leaves
    localparam int Nodes = 2**(Lvls+1) - 1;

    logic [Nodes-1:0]                     req_tree;
    logic [Nodes-1:0]                     prio_tree;
    logic [Nodes-1:0]                     sel_tree;
    logic [Nodes-1:0]                     mask_tree;
    logic [Nodes-1:0][arb_pkg::IdxW-1:0]  idx_tree;
    logic [Nodes-1:0][DW-1:0]             data_tree;
    logic [N-1:0]                         prio_mask_d;
    logic [N-1:0]                         prio_mask_q;

    for (genvar lvl = 0; lvl <= Lvls; lvl++) begin : gen_level
      // first node index on this level and on the level of its children
      localparam int Base0 = (2**lvl) - 1;
      localparam int Base1 = (2**(lvl+1)) - 1;

      for (genvar ofs = 0; ofs < 2**lvl; ofs++) begin : gen_node
        localparam int Pa = Base0 + ofs;
        localparam int C0 = Base1 + 2*ofs;
        localparam int C1 = Base1 + 2*ofs + 1;

        if (lvl == Lvls) begin : gen_leaf
          if (ofs < N) begin : gen_used
            // every request takes part in the plain tree
            assign req_tree[Pa]  = req_i[ofs];
            // high priority only above the last winner
            assign prio_tree[Pa] = req_i[ofs] & prio_mask_q[ofs];
            assign idx_tree[Pa]  = arb_pkg::IdxW'(ofs);
            assign data_tree[Pa] = data_i[ofs];

            // the one-hot select comes back from the root
            assign gnt_o[ofs] = req_i[ofs] & sel_tree[Pa] & ready_i;

            // when stalled the winner is kept in the mask so it wins again
            assign prio_mask_d[ofs] = (|req_i) ?
                                      (mask_tree[Pa] | (sel_tree[Pa] & ~ready_i)) :
                                      prio_mask_q[ofs];
          end else begin : gen_pad
            // padding leaves never request
            assign req_tree[Pa]  = 1'b0;
            assign prio_tree[Pa] = 1'b0;
            assign idx_tree[Pa]  = '0;
            assign data_tree[Pa] = '0;
          end
        end else begin : gen_inner
          logic sel;

          // take the right child if the left is idle, or only the right has priority
          assign sel = ~req_tree[C0] | (~prio_tree[C0] & prio_tree[C1]);

          assign req_tree[Pa]  = req_tree[C0] | req_tree[C1];
          assign prio_tree[Pa] = prio_tree[C0] | prio_tree[C1];
          assign idx_tree[Pa]  = sel ? idx_tree[C1] : idx_tree[C0];
          assign data_tree[Pa] = sel ? data_tree[C1] : data_tree[C0];

          // push the select down to exactly one leaf
          assign sel_tree[C0] = sel_tree[Pa] & ~sel;
          assign sel_tree[C1] = sel_tree[Pa] & sel;
          // everything right of the selected leaf gets its mask bit set
          assign mask_tree[C0] = mask_tree[Pa];
          assign mask_tree[C1] = mask_tree[Pa] | sel_tree[C0];
        end
      end
    end

    ////////////////////
    // root and mask
    ////////////////////

    assign valid_o = req_tree[0];
    assign idx_o   = idx_tree[0];
    assign data_o  = data_tree[0];

    // the root always selects, the prefix sum starts from zero
    assign sel_tree[0]  = 1'b1;
    assign mask_tree[0] = 1'b0;

    // mask of zero after reset lets the lowest index win first
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        prio_mask_q <= '0;
      end else begin
        prio_mask_q <= prio_mask_d;
      end
    end

  end

endmodule

`default_nettype wire

// ==== chan_queue.sv ====
// per-channel message queue
// circular buffer with a count, requests while non-empty and enabled

`timescale 1ns/100ps
`default_nettype none

`include "arb_defs.svh"

module chan_queue #(
  parameter int DW    = `ARB_DW,
  parameter int DEPTH = `ARB_QDEPTH
) (
  input  wire           clk_i,
  input  wire           rst_ni,
  input  wire           push_i,
  input  wire  [DW-1:0] push_data_i,
  output logic          full_o,
  input  wire           en_i,
  output logic          req_o,
  output logic [DW-1:0] head_o,
  input  wire           pop_i
);

  localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CntW = $clog2(DEPTH + 1);

  logic [DW-1:0]   mem [DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            empty;
  logic            do_push;
  logic            do_pop;

  assign empty  = (count_q == '0);
  assign full_o = (count_q == CntW'(DEPTH));

  // a disabled channel keeps its words but stops asking
  assign req_o  = ~empty & en_i;
  assign head_o = mem[rd_ptr_q];

  // the grant only comes with a request, the empty check is a guard
  assign do_pop  = pop_i & ~empty;
  // a full queue still takes a word when the head leaves on the same edge
  assign do_push = push_i & (~full_o | do_pop);

  // storage has no reset, only words below the count are ever read
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // push and pop together leave the count unchanged
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== arb_cfg_regs.sv ====
// config registers beside the arbiter
// channel enable mask and one wrapping grant counter per channel

`timescale 1ns/100ps
`default_nettype none

`include "arb_defs.svh"

module arb_cfg_regs (
  input  wire                   clk_i,
  input  wire                   rst_ni,
  input  wire                   cfg_we_i,
  input  wire  [`ARB_ADDRW-1:0] cfg_addr_i,
  input  wire  [`ARB_CNTW-1:0]  cfg_wdata_i,
  output logic [`ARB_CNTW-1:0]  cfg_rdata_o,
  input  wire  [`ARB_N-1:0]     gnt_i,
  output logic [`ARB_N-1:0]     chan_en_o
);

  logic [`ARB_N-1:0]    en_q;
  logic [`ARB_CNTW-1:0] cnt_q [`ARB_N];
  logic                 en_we;

  assign en_we = cfg_we_i & (cfg_addr_i == arb_pkg::ARB_REG_ENABLE);

  ////////////////////
  // enable mask
  ////////////////////

  // all channels come out of reset enabled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q <= '1;
    end else if (en_we) begin
      en_q <= cfg_wdata_i[`ARB_N-1:0];
    end
  end

  assign chan_en_o = en_q;

  ////////////////////
  // grant counters
  ////////////////////

  for (genvar i = 0; i < `ARB_N; i++) begin : gen_cnt
    // counter i lives at the address after the one before it
    localparam logic [`ARB_ADDRW-1:0] CntAddr =
      `ARB_ADDRW'(int'(arb_pkg::ARB_REG_CNT0) + i);

    logic clr;

    // the written value is ignored, any write just clears
    assign clr = cfg_we_i & (cfg_addr_i == CntAddr);

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[i] <= '0;
      end else if (clr) begin
        // clearing wins over a grant on the same edge
        cnt_q[i] <= '0;
      end else if (gnt_i[i]) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  // read data is purely combinational from the address
  always_comb begin
    cfg_rdata_o = '0;
    case (arb_pkg::arb_reg_e'(cfg_addr_i))
      arb_pkg::ARB_REG_ENABLE: cfg_rdata_o = `ARB_CNTW'(en_q);
      arb_pkg::ARB_REG_CNT0:   cfg_rdata_o = cnt_q[0];
      arb_pkg::ARB_REG_CNT1:   cfg_rdata_o = cnt_q[1];
      arb_pkg::ARB_REG_CNT2:   cfg_rdata_o = cnt_q[2];
      arb_pkg::ARB_REG_CNT3:   cfg_rdata_o = cnt_q[3];
      default:                 cfg_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== msg_concentrator.sv ====
// top level of the four-channel message concentrator
// channel queues feed the tree arbiter, the register block steers it

`timescale 1ns/100ps
`default_nettype none

`include "arb_defs.svh"

module msg_concentrator (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  wire  [`ARB_N-1:0]        push_i,
  input  wire  [`ARB_DW-1:0]       push_data_i [`ARB_N],
  output logic [`ARB_N-1:0]        full_o,
  input  wire                      cfg_we_i,
  input  wire  [`ARB_ADDRW-1:0]    cfg_addr_i,
  input  wire  [`ARB_CNTW-1:0]     cfg_wdata_i,
  output logic [`ARB_CNTW-1:0]     cfg_rdata_o,
  output logic                     valid_o,
  output logic [`ARB_DW-1:0]       data_o,
  output logic [arb_pkg::IdxW-1:0] chan_o,
  input  wire                      ready_i
);

  logic [`ARB_N-1:0]  req;
  logic [`ARB_N-1:0]  gnt;
  logic [`ARB_N-1:0]  chan_en;
  logic [`ARB_DW-1:0] head [`ARB_N];

  // one queue per channel, each popped by its own grant bit
  for (genvar i = 0; i < `ARB_N; i++) begin : gen_queue
    chan_queue #(
      .DW    (`ARB_DW),
      .DEPTH (`ARB_QDEPTH)
    ) u_queue (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .push_i      (push_i[i]),
      .push_data_i (push_data_i[i]),
      .full_o      (full_o[i]),
      .en_i        (chan_en[i]),
      .req_o       (req[i]),
      .head_o      (head[i]),
      .pop_i       (gnt[i])
    );
  end

  // the winner index goes straight out as the channel tag
  rr_arbiter_tree #(
    .N  (`ARB_N),
    .DW (`ARB_DW)
  ) u_arb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req),
    .data_i  (head),
    .gnt_o   (gnt),
    .idx_o   (chan_o),
    .valid_o (valid_o),
    .data_o  (data_o),
    .ready_i (ready_i)
  );

  arb_cfg_regs u_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .gnt_i       (gnt),
    .chan_en_o   (chan_en)
  );

endmodule

`default_nettype wire

// ==== arb_checker.sv ====
// concurrent assertions for the round-robin tree arbiter
// one-hot grant, grant tied to the transfer, held winner, muxed data

`timescale 1ns/100ps
`default_nettype none

`include "arb_defs.svh"

module arb_checker #(
  parameter int N  = `ARB_N,
  parameter int DW = `ARB_DW
) (
  input wire                     clk_i,
  input wire                     rst_ni,
  input wire [N-1:0]             req_i,
  input wire [DW-1:0]            data_i [N],
  input wire [N-1:0]             gnt_o,
  input wire [arb_pkg::IdxW-1:0] idx_o,
  input wire                     valid_o,
  input wire [DW-1:0]            data_o,
  input wire                     ready_i
);

  // at most one queue is popped on any edge
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_o))
    else $error("arbiter grant vector has more than one bit set");

  // a grant needs the sink ready and goes to the channel shown on the output
  // every transfer on the output pops exactly that channel
  a_gnt_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|gnt_o || (valid_o && ready_i)) |-> (ready_i && valid_o && gnt_o[idx_o]))
    else $error("arbiter grant does not match a transfer on the selected channel");

  // a stalled winner stays selected while it still asks
  a_idx_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && !ready_i) |=> (!req_i[$past(idx_o)] || idx_o == $past(idx_o)))
    else $error("arbiter changed the selected channel under back-pressure");

  // output word is the head of the selected channel
  a_data_mux: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> data_o == data_i[idx_o])
    else $error("arbiter output data does not match the selected input");

endmodule

`default_nettype wire

// ==== tb_msg_concentrator.sv ====
// testbench for the message concentrator
// directed stimulus table, then an LCG driven random phase
// queue and round-robin reference model, checks, timeout and result line

`timescale 1ns/100ps
`default_nettype none

`include "arb_defs.svh"

module tb_msg_concentrator;

  localparam int NumRows    = 43;
  localparam int RandCycles = 300;
  localparam int MaxCycles  = NumRows + RandCycles + 200;

  // what the table row expects on top of the model compare
  localparam logic [3:0] KNONE = 4'd0;
  localparam logic [3:0] KDATA = 4'd1;
  localparam logic [3:0] KREAD = 4'd2;
  localparam logic [3:0] KIDLE = 4'd3;
  localparam logic [3:0] KFULL = 4'd4;

  logic                     clk_i;
  logic                     rst_ni;
  logic [`ARB_N-1:0]        push_i;
  logic [`ARB_DW-1:0]       push_data_i [`ARB_N];
  logic [`ARB_N-1:0]        full_o;
  logic                     cfg_we_i;
  logic [`ARB_ADDRW-1:0]    cfg_addr_i;
  logic [`ARB_CNTW-1:0]     cfg_wdata_i;
  logic [`ARB_CNTW-1:0]     cfg_rdata_o;
  logic                     valid_o;
  logic [`ARB_DW-1:0]       data_o;
  logic [arb_pkg::IdxW-1:0] chan_o;
  logic                     ready_i;

  // reference model state, one queue per channel
  logic [`ARB_DW-1:0]   mq [`ARB_N][$];
  logic [`ARB_N-1:0]    m_en;
  logic [`ARB_CNTW-1:0] m_cnt [`ARB_N];
  int                   m_last;
  logic [11:0]          seq [`ARB_N];
  logic [31:0]          lcg_state;
  int                   errors  = 0;
  int                   checked = 0;
  int                   cycles  = 0;

  // columns: push mask, ready, cfg write, cfg addr, wdata, expect kind, expected value
  // a pushed word is {channel + 1, per-channel sequence number}
  logic [51:0] stim [NumRows] = '{
    52'h0_1_0_0_0000_3_0000, 52'h1_0_0_0_0000_3_0000, 52'h0_1_0_0_0000_1_1000,
    52'h0_1_0_0_0000_3_0000, 52'hF_0_0_0_0000_3_0000, 52'hF_0_0_0_0000_1_2000,
    52'h0_1_0_0_0000_1_2000, 52'h0_1_0_0_0000_1_3000, 52'h0_1_0_0_0000_1_4000,
    52'h0_1_0_0_0000_1_1001, 52'h0_1_0_0_0000_1_2001, 52'h0_1_0_0_0000_1_3001,
    52'h0_1_0_0_0000_1_4001, 52'h0_1_0_0_0000_1_1002, 52'h0_1_0_0_0000_3_0000,
    52'h7_0_0_0_0000_3_0000, 52'h0_0_0_0_0000_1_2002, 52'h0_0_0_0_0000_1_2002,
    52'h0_0_0_0_0000_1_2002, 52'h0_1_0_0_0000_1_2002, 52'h0_1_0_0_0000_1_3002,
    52'h0_1_0_0_0000_1_1003, 52'h0_1_0_0_0000_3_0000, 52'h6_0_1_0_000B_2_000F,
    52'h0_0_0_0_0000_2_000B, 52'h0_1_0_0_0000_1_2003, 52'h0_1_0_0_0000_3_0000,
    52'h0_1_1_0_000F_3_0000, 52'h0_1_0_0_0000_1_3003, 52'h0_1_0_0_0000_3_0000,
    52'h8_0_0_1_0000_2_0004, 52'h8_0_0_4_0000_2_0002, 52'h8_0_0_2_0000_2_0004,
    52'h8_0_0_3_0000_2_0004, 52'h8_0_0_0_0000_4_0008, 52'h0_1_0_0_0000_1_4002,
    52'h0_1_0_0_0000_1_4003, 52'h0_1_0_0_0000_1_4004, 52'h0_1_0_0_0000_1_4005,
    52'h0_1_0_4_0000_2_0006, 52'h0_1_1_4_1234_2_0006, 52'h0_1_0_4_0000_2_0000,
    52'h0_1_0_0_0000_2_000F
  };

  msg_concentrator uut (.*);

  // assertions ride along inside every arbiter instance
  bind rr_arbiter_tree arb_checker #(.N(N), .DW(DW)) u_arb_checker (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(req_i), .data_i(data_i), .gnt_o(gnt_o),
    .idx_o(idx_o), .valid_o(valid_o), .data_o(data_o), .ready_i(ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // hard stop in case the sequence stalls
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("timeout: the test sequence did not finish within %0d cycles", MaxCycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [`ARB_DW-1:0] make_word(input int ch, input logic [11:0] n);
    return {4'(ch + 1), n};
  endfunction

  // lowest requester above the last winner, else the lowest overall, -1 if none
  function automatic int pick_winner();
    int                w;
    logic [`ARB_N-1:0] req;
    w = -1;
    for (int i = 0; i < `ARB_N; i++) begin
      req[i] = (mq[i].size() > 0) && m_en[i];
    end
    for (int i = `ARB_N - 1; i > m_last; i--) begin
      if (req[i]) w = i;
    end
    if (w < 0) begin
      for (int i = `ARB_N - 1; i >= 0; i--) begin
        if (req[i]) w = i;
      end
    end
    return w;
  endfunction

  function automatic logic [`ARB_CNTW-1:0] model_read(input logic [`ARB_ADDRW-1:0] a);
    if (a == 0) return `ARB_CNTW'(m_en);
    if (a <= `ARB_N) return m_cnt[a-1];
    return '0;
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  // new inputs go out just after the rising edge
  task automatic drive(input logic [`ARB_N-1:0] push, input logic rdy, input logic we,
                       input logic [`ARB_ADDRW-1:0] addr, input logic [`ARB_CNTW-1:0] wdata);
    @(posedge clk_i);
    push_i <= push;
    for (int i = 0; i < `ARB_N; i++) begin
      push_data_i[i] <= make_word(i, seq[i]);
      if (push[i]) seq[i] = seq[i] + 12'd1;
    end
    ready_i     <= rdy;
    cfg_we_i    <= we;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= wdata;
  endtask

  // compare at the falling edge, then move the model across the next rising edge
  task automatic check_and_step(input logic [3:0] kind, input logic [15:0] val);
    int                       w;
    logic [`ARB_CNTW-1:0]     rd;
    logic [arb_pkg::IdxW-1:0] exp_ch;
    @(negedge clk_i);
    checked++;
    w      = pick_winner();
    rd     = model_read(cfg_addr_i);
    exp_ch = arb_pkg::IdxW'(val[15:12] - 4'd1);
    if (valid_o !== (w >= 0)) begin
      report_mismatch($sformatf("valid_o is %b, model winner %0d", valid_o, w));
    end else if (w >= 0 && (chan_o !== arb_pkg::IdxW'(w) || data_o !== mq[w][0])) begin
      report_mismatch($sformatf("chan %0d data %h, expected chan %0d data %h",
                                chan_o, data_o, w, mq[w][0]));
    end
    for (int i = 0; i < `ARB_N; i++) begin
      if (full_o[i] !== (mq[i].size() == `ARB_QDEPTH)) begin
        report_mismatch($sformatf("full_o[%0d] is %b with %0d words", i, full_o[i],
                                  mq[i].size()));
      end
    end
    if (cfg_rdata_o !== rd) begin
      report_mismatch($sformatf("read of addr %0d gave %h, expected %h", cfg_addr_i,
                                cfg_rdata_o, rd));
    end
    // the table's own expected column
    if (kind == KDATA && (valid_o !== 1'b1 || data_o !== val || chan_o !== exp_ch)) begin
      report_mismatch($sformatf("table expects word %h, got %h on chan %0d", val, data_o,
                                chan_o));
    end
    if (kind == KREAD && cfg_rdata_o !== val) begin
      report_mismatch($sformatf("table expects read %h, got %h", val, cfg_rdata_o));
    end
    if (kind == KIDLE && valid_o !== 1'b0) begin
      report_mismatch("table expects valid_o low");
    end
    if (kind == KFULL && full_o !== val[`ARB_N-1:0]) begin
      report_mismatch($sformatf("table expects full_o %b, got %b", val[3:0], full_o));
    end
    // a transfer pops the winner, a stall keeps it first in line
    if (w >= 0 && ready_i) begin
      void'(mq[w].pop_front());
      m_cnt[w] = m_cnt[w] + 1'b1;
      m_last   = w;
    end else if (w >= 0) begin
      m_last = w - 1;
    end
    for (int i = 0; i < `ARB_N; i++) begin
      if (push_i[i] && mq[i].size() < `ARB_QDEPTH) mq[i].push_back(push_data_i[i]);
    end
    // a clearing write lands after the increment so it wins
    if (cfg_we_i && cfg_addr_i == 0) begin
      m_en = cfg_wdata_i[`ARB_N-1:0];
    end else if (cfg_we_i && cfg_addr_i <= `ARB_N) begin
      m_cnt[cfg_addr_i-1] = '0;
    end
  endtask

  initial begin
    logic [51:0] row;
    logic [31:0] r;
    rst_ni      = 1'b0;
    push_i      = '0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    ready_i     = 1'b0;
    m_en        = '1;
    m_last      = -1;
    lcg_state   = 32'h7e1d_7d44;
    for (int i = 0; i < `ARB_N; i++) begin
      push_data_i[i] = '0;
      m_cnt[i]       = '0;
      seq[i]         = '0;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    ////////////////////
    // directed table
    ////////////////////
    for (int n = 0; n < NumRows; n++) begin
      row = stim[n];
      drive(row[51:48], row[44], row[40], row[38:36], row[35:20]);
      check_and_step(row[19:16], row[15:0]);
    end

    ////////////////////
    // random phase
    ////////////////////
    // ready is high three times in four, a config write comes about once in 16 cycles
    for (int n = 0; n < RandCycles; n++) begin
      lcg_state = lcg_next(lcg_state);
      r         = lcg_state;
      drive(r[27:24], r[31:30] != 2'b00, r[19:16] == 4'h0, r[22:20], r[15:0]);
      check_and_step(KNONE, '0);
    end

    $display("checked %0d cycles, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
arb_pkg.sv
rr_arbiter_tree.sv
chan_queue.sv
arb_cfg_regs.sv
msg_concentrator.sv
arb_checker.sv
tb_msg_concentrator.sv

// ==== Makefile ====
# Verilator build and run for the message concentrator testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_msg_concentrator
FILELIST := tb.f
LOG      := sim.log

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
